// ==== verification/pcap_ingress_patterns.txt ====
// Header per packet: tuser in [39:8], expected qid in [7:4], beat count in [3:0]
// Then one line per beat as tstrb in [71:64] and tdata in [63:0]
// Then beats+1 expected words as upper half in [71:36] and lower half in [35:0]
01000A0101
FF0706050403020100
80402010080C021501
83C1A0B0481C0A0300
04000A0212
FF1716151413121110
0F000000001B1A1918
804020100824021502
8BC5A2B1489C4A2310
0000000008DC6A3318
10000A0321
FFFFEEDDCCBBAA9988
804020100884021503
FFFBBBBCCDDEAB3388
40000A0431
81A50000000000005A
804020100A04021504
D2800000000000015A
50000A0531
FF0123456789ABCDEF
804020100A84021505
80C8E8B67C4EAF9BEF
0

// ==== pcap_ingress_top.f ====
+incdir+verilog
verilog/axis_types_pkg.sv
verilog/replay_regs_pkg.sv
verilog/axis_skid_fifo.sv
verilog/pkt_framer.sv
verilog/replay_fifo.sv
verilog/replay_apb_regs.sv
verilog/pcap_ingress_top.sv
verification/pcap_ingress_assertions.sv
verification/pcap_ingress_tb.sv

// ==== Bender.yml ====
package:
  name: pcap_ingress

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axis_types_pkg.sv
      - verilog/replay_regs_pkg.sv
      - verilog/axis_skid_fifo.sv
      - verilog/pkt_framer.sv
      - verilog/replay_fifo.sv
      - verilog/replay_apb_regs.sv
      - verilog/pcap_ingress_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/pcap_ingress_assertions.sv
      - verification/pcap_ingress_tb.sv

// ==== verification/pcap_ingress_tb.sv ====
// ==========================================================
// Testbench for the PCAP ingress stage
// Pattern-driven packets, APB control, half-word scoreboard
// ==========================================================
`timescale 1ns/1ps
`include "pcap_ingress_config.svh"

module pcap_ingress_tb;

  localparam int MAX_PKTS = 16;
  localparam int PAT_LINES = 64;
  // Framing, two back-pressure passes, flush pass
  localparam int PASSES = 4;

  logic                       axi_aclk;
  logic                       rst_n;
  axis_types_pkg::axis_beat_t s_axis;
  logic                       s_axis_tvalid;
  logic                       s_axis_tready;
  replay_regs_pkg::apb_req_t  apb_req;
  replay_regs_pkg::apb_rsp_t  apb_rsp;
  logic                       fifo_rd_en;
  logic [`PI_OUT_W-1:0]       fifo_dout;
  logic [`PI_QID_W-1:0]       fifo_dout_qid;
  logic                       fifo_empty;

  // Pattern records as laid out in the patterns file header
  logic [71:0] pat_mem [0:PAT_LINES-1];
  int          pkt_start [MAX_PKTS];
  int          num_pkts;
  int          num_entries;
  int          watchdog_cycles;

  // Scoreboard queues with the lower half pushed first
  logic [`PI_OUT_W-1:0] exp_half [$];
  logic [`PI_QID_W-1:0] exp_qid [$];
  int                   error_count;
  int                   check_count;

  pcap_ingress_top UUT (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .s_axis        (s_axis),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .fifo_rd_en    (fifo_rd_en),
    .fifo_dout     (fifo_dout),
    .fifo_dout_qid (fifo_dout_qid),
    .fifo_empty    (fifo_empty)
  );

  always #50 axi_aclk = ~axi_aclk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Header line index of every packet up to a zero header
  task automatic parse_patterns();
    int idx;
    int len;
    idx = 0;
    num_pkts = 0;
    num_entries = 0;
    while (idx < PAT_LINES && num_pkts < MAX_PKTS && !$isunknown(pat_mem[idx])
           && pat_mem[idx][3:0] != 4'h0) begin
      len = pat_mem[idx][3:0];
      pkt_start[num_pkts] = idx;
      num_pkts++;
      num_entries += len + 1;
      idx += 2 * len + 2;
    end
  endtask

  // Zero wait-state APB access sampled mid access phase
  task automatic reg_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    replay_regs_pkg::apb_req_t req;
    req = '0;
    req.psel = 1'b1;
    req.pwrite = wr;
    req.paddr = addr;
    req.pwdata = wdata;
    @(posedge axi_aclk);
    apb_req <= req;
    @(posedge axi_aclk);
    req.penable = 1'b1;
    apb_req <= req;
    @(negedge axi_aclk);
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    check_value("apb_pready", 32'h1, apb_rsp.pready);
    @(posedge axi_aclk);
    apb_req <= '0;
  endtask

  // Returns at the negedge before the transfer edge
  task automatic drive_beat(input axis_types_pkg::axis_beat_t beat, input bit gaps);
    bit accepted;
    while (gaps && ($urandom % 4 == 0)) begin
      @(posedge axi_aclk);
      s_axis_tvalid <= 1'b0;
    end
    @(posedge axi_aclk);
    s_axis <= beat;
    s_axis_tvalid <= 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge axi_aclk);
      if (s_axis_tready) begin
        accepted = 1'b1;
      end else begin
        @(posedge axi_aclk);
      end
    end
  endtask

  task automatic send_packet(input int p, input bit gaps);
    axis_types_pkg::axis_beat_t beat;
    logic [71:0] hdr;
    logic [71:0] word;
    int base;
    int len;
    base = pkt_start[p];
    hdr = pat_mem[base];
    len = hdr[3:0];
    // Expected metadata word, then one word per beat
    for (int e = 0; e <= len; e++) begin
      word = pat_mem[base + len + 1 + e];
      exp_half.push_back(word[`PI_OUT_W-1:0]);
      exp_half.push_back(word[`PI_PACKED_W-1:`PI_OUT_W]);
      exp_qid.push_back(hdr[4 +: `PI_QID_W]);
      exp_qid.push_back(hdr[4 +: `PI_QID_W]);
    end
    for (int b = 0; b < len; b++) begin
      beat.tdata = pat_mem[base + 1 + b][63:0];
      beat.tstrb = pat_mem[base + 1 + b][71:64];
      beat.tuser = hdr[39:8];
      beat.tlast = (b == len - 1);
      drive_beat(beat, gaps);
    end
  endtask

  task automatic stream_all_packets(input bit gaps);
    for (int p = 0; p < num_pkts; p++) begin
      send_packet(p, gaps);
    end
    @(posedge axi_aclk);
    s_axis_tvalid <= 1'b0;
  endtask

  // Consume at the edge after the negedge sample
  task automatic drain_output(input int count, input bit gaps, input string name);
    logic [`PI_OUT_W-1:0] want;
    logic [`PI_QID_W-1:0] want_qid;
    int got;
    got = 0;
    while (got < count) begin
      @(posedge axi_aclk);
      fifo_rd_en <= !gaps || ($urandom % 3 != 0);
      @(negedge axi_aclk);
      if (fifo_rd_en && !fifo_empty) begin
        got++;
        check_count++;
        if (exp_half.size() == 0) begin
          error_count++;
          $display("Unexpected half-word %0d in %s with nothing left to expect", got, name);
        end else begin
          want = exp_half.pop_front();
          want_qid = exp_qid.pop_front();
          if (fifo_dout !== want || fifo_dout_qid !== want_qid) begin
            error_count++;
            $display("Error: %s half-word %0d expected %h q%0d actual %h q%0d", name, got,
                     want, want_qid, fifo_dout, fifo_dout_qid);
          end
        end
      end
    end
    @(posedge axi_aclk);
    fifo_rd_en <= 1'b0;
  endtask

  // Valid high with ready low, then hold the stall a while
  task automatic wait_for_stall(output bit stalled);
    stalled = 1'b0;
    for (int i = 0; i < 500 && !stalled; i++) begin
      @(negedge axi_aclk);
      if (s_axis_tvalid && !s_axis_tready) begin
        stalled = 1'b1;
      end
    end
    repeat (20) @(posedge axi_aclk);
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    bit          stalled;
    int          polls;
    void'($urandom(31351));
    axi_aclk = 1'b0;
    rst_n = 1'b0;
    s_axis = '0;
    s_axis_tvalid = 1'b0;
    apb_req = '0;
    fifo_rd_en = 1'b0;
    error_count = 0;
    check_count = 0;
    watchdog_cycles = 0;
    $readmemh("verification/pcap_ingress_patterns.txt", pat_mem);
    parse_patterns();
    if (num_pkts == 0) begin
      error_count++;
      $display("No packets found in the patterns file");
    end
    // 200 cycles for every beat sent over the run
    watchdog_cycles = 200 * (num_entries - num_pkts) * PASSES;
    repeat (10) @(posedge axi_aclk);
    rst_n <= 1'b1;

    // Register reset values and access errors
    reg_access(1'b0, `PI_REG_CTRL, 32'h0, rdata, err);
    check_value("ctrl_reset", 32'h0, rdata);
    @(negedge axi_aclk);
    check_value("tready_reset", 32'h0, s_axis_tready);
    check_value("fifo_empty_reset", 32'h1, fifo_empty);
    reg_access(1'b1, `PI_REG_CTRL, 32'h1, rdata, err);
    check_value("ctrl_write_slverr", 32'h0, err);
    reg_access(1'b0, `PI_REG_CTRL, 32'h0, rdata, err);
    check_value("ctrl_readback", 32'h1, rdata);
    reg_access(1'b1, `PI_REG_PKT_COUNT, 32'h5, rdata, err);
    check_value("slverr_pkt_count", 32'h1, err);
    reg_access(1'b1, 4'hC, 32'h5, rdata, err);
    check_value("slverr_unmapped", 32'h1, err);

    // Framing and queue ids with random gaps on both sides
    fork
      stream_all_packets(1'b1);
      drain_output(2 * num_entries, 1'b1, "framing");
    join

    // Two passes overflow the buffer before reads start
    fork
      begin
        stream_all_packets(1'b0);
        stream_all_packets(1'b0);
      end
      begin
        wait_for_stall(stalled);
        // Full buffer keeps the skid FIFO full
        @(negedge axi_aclk);
        check_value("tready_buffer_full", 32'h0, s_axis_tready);
        drain_output(4 * num_entries, 1'b1, "backpressure");
      end
    join
    check_value("tready_stall", 32'h1, stalled);
    @(negedge axi_aclk);
    check_value("drained_fifo_empty", 32'h1, fifo_empty);
    reg_access(1'b0, `PI_REG_PKT_COUNT, 32'h0, rdata, err);
    check_value("pkt_count", 3 * num_pkts, rdata);

    // Refill without reads, then flush
    stream_all_packets(1'b1);
    polls = 0;
    rdata = '0;
    while (rdata != 4 * num_pkts && polls < 100) begin
      reg_access(1'b0, `PI_REG_PKT_COUNT, 32'h0, rdata, err);
      polls++;
    end
    check_value("pkt_count_before_flush", 4 * num_pkts, rdata);
    reg_access(1'b1, `PI_REG_CTRL, 32'h0, rdata, err);
    reg_access(1'b0, `PI_REG_STATUS, 32'h0, rdata, err);
    check_value("flush_fifo_empty", 32'h1, rdata[0]);
    reg_access(1'b0, `PI_REG_PKT_COUNT, 32'h0, rdata, err);
    check_value("flush_pkt_count", 32'h0, rdata);
    exp_half.delete();
    exp_qid.delete();

    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
             UUT.u_assertions.fail_count);
    if (error_count == 0 && UUT.u_assertions.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge axi_aclk);
    $display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verification/pcap_ingress_assertions.sv ====
// ==========================================================
// Handshake assertions bound into the ingress top level
// ==========================================================
`timescale 1ns/1ps
`include "pcap_ingress_config.svh"

module pcap_ingress_assertions (
  input logic                       axi_aclk,
  input logic                       rst_n,
  input axis_types_pkg::axis_beat_t s_axis,
  input logic                       s_axis_tvalid,
  input logic                       s_axis_tready,
  input replay_regs_pkg::apb_req_t  apb_req,
  input replay_regs_pkg::apb_rsp_t  apb_rsp,
  input logic                       enable,
  input logic                       fifo_empty
);

  // Number of failed assertions
  int fail_count = 0;

  // Stalled beat holds until taken
  a_stream_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis))
    else begin
      fail_count++;
      $error("Stream beat changed while stalled");
    end

  // Error response only in the access phase
  // Raised for an unmapped offset or a write to a read-only register
  a_slverr_phase: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    apb_rsp.pslverr == (apb_req.psel && apb_req.penable &&
      (!(apb_req.paddr inside {`PI_REG_CTRL, `PI_REG_STATUS, `PI_REG_PKT_COUNT}) ||
       (apb_req.pwrite && apb_req.paddr != `PI_REG_CTRL))))
    else begin
      fail_count++;
      $error("pslverr does not match the access phase and address");
    end

  // Flush lands one edge after enable drops
  a_flush_empty: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    $fell(enable) |=> fifo_empty)
    else begin
      fail_count++;
      $error("Buffer not empty after disable");
    end

endmodule

bind pcap_ingress_top pcap_ingress_assertions u_assertions (
  .axi_aclk      (axi_aclk),
  .rst_n         (rst_n),
  .s_axis        (s_axis),
  .s_axis_tvalid (s_axis_tvalid),
  .s_axis_tready (s_axis_tready),
  .apb_req       (apb_req),
  .apb_rsp       (apb_rsp),
  .enable        (enable),
  .fifo_empty    (fifo_empty)
);

// ==== verilog/pcap_ingress_top.sv ====
// ==========================================================
// PCAP replay ingress stage
// Stream in, framed replay buffer out, APB control
// ==========================================================
`timescale 1ns/1ps
`include "pcap_ingress_config.svh"

module pcap_ingress_top (
  input  logic                       axi_aclk,
  input  logic                       rst_n,
  input  axis_types_pkg::axis_beat_t s_axis,
  input  logic                       s_axis_tvalid,
  output logic                       s_axis_tready,
  input  replay_regs_pkg::apb_req_t  apb_req,
  output replay_regs_pkg::apb_rsp_t  apb_rsp,
  input  logic                       fifo_rd_en,
  output logic [`PI_OUT_W-1:0]       fifo_dout,
  output logic [`PI_QID_W-1:0]       fifo_dout_qid,
  output logic                       fifo_empty
);

  // Skid FIFO head towards the framer
  axis_types_pkg::axis_beat_t head;
  logic                       skid_empty;
  logic                       skid_pop;

  // Framer write port into the buffer
  axis_types_pkg::buf_entry_t wr_entry;
  logic                       wr_en;
  logic                       buf_full;

  // Control and status
  logic enable;
  logic pkt_done;
  logic state_bit;

  axis_skid_fifo u_skid (
    .axi_aclk (axi_aclk),
    .rst_n    (rst_n),
    .enable   (enable),
    .in_beat  (s_axis),
    .in_valid (s_axis_tvalid),
    .in_ready (s_axis_tready),
    .head     (head),
    .empty    (skid_empty),
    .pop      (skid_pop)
  );

  pkt_framer u_framer (
    .axi_aclk  (axi_aclk),
    .rst_n     (rst_n),
    .enable    (enable),
    .head      (head),
    .empty     (skid_empty),
    .pop       (skid_pop),
    .full      (buf_full),
    .wr_entry  (wr_entry),
    .wr_en     (wr_en),
    .pkt_done  (pkt_done),
    .state_bit (state_bit)
  );

  replay_fifo u_buf (
    .axi_aclk (axi_aclk),
    .rst_n    (rst_n),
    .enable   (enable),
    .wr_entry (wr_entry),
    .wr_en    (wr_en),
    .full     (buf_full),
    .rd_en    (fifo_rd_en),
    .dout     (fifo_dout),
    .dout_qid (fifo_dout_qid),
    .empty    (fifo_empty)
  );

  replay_apb_regs u_regs (
    .axi_aclk   (axi_aclk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .enable     (enable),
    .pkt_done   (pkt_done),
    .fifo_empty (fifo_empty),
    .state_bit  (state_bit)
  );

endmodule

// ==== verilog/replay_apb_regs.sv ====
// ==========================================================
// APB register block: enable, status, packet counter
// Zero wait states, error on bad address or read-only write
// ==========================================================
`timescale 1ns/1ps

module replay_apb_regs (
  input  logic                      axi_aclk,
  input  logic                      rst_n,
  input  replay_regs_pkg::apb_req_t apb_req,
  output replay_regs_pkg::apb_rsp_t apb_rsp,
  output logic                      enable,
  input  logic                      pkt_done,
  input  logic                      fifo_empty,
  input  logic                      state_bit
);

  replay_regs_pkg::reg_addr_e reg_addr;

  logic        ctrl_en;
  logic [31:0] pkt_count;
  logic [31:0] rd_data;
  logic        addr_hit;
  logic        access;
  logic        wr_ctrl;
  logic        bad_write;

  // Access phase only
  assign access = apb_req.psel && apb_req.penable;

  // Address decode and read mux
  always_comb begin
    reg_addr = replay_regs_pkg::reg_addr_e'(apb_req.paddr);
    addr_hit = 1'b1;
    rd_data  = '0;
    case (reg_addr)
      replay_regs_pkg::CTRL:      rd_data = {31'b0, ctrl_en};
      replay_regs_pkg::STATUS:    rd_data = {30'b0, state_bit, fifo_empty};
      replay_regs_pkg::PKT_COUNT: rd_data = pkt_count;
      default:                    addr_hit = 1'b0;
    endcase
  end

  // STATUS and PKT_COUNT are read-only
  assign bad_write = apb_req.pwrite && (reg_addr != replay_regs_pkg::CTRL);
  assign wr_ctrl   = access && apb_req.pwrite && (reg_addr == replay_regs_pkg::CTRL);

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && (!addr_hit || bad_write);

  assign enable = ctrl_en;

  // Enable bit, written at the access edge
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_en <= 1'b0;
    end else if (wr_ctrl) begin
      ctrl_en <= apb_req.pwdata[0];
    end
  end

  // Packet counter, held at zero while disabled
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_count <= '0;
    end else if (!ctrl_en) begin
      pkt_count <= '0;
    end else if (pkt_done) begin
      pkt_count <= pkt_count + 1'b1;
    end
  end

endmodule

// ==== verilog/replay_fifo.sv ====
// ==========================================================
// Replay buffer, 72-bit entries read out as 36-bit halves
// Lower half first, queue id held per entry
// ==========================================================
`timescale 1ns/1ps
`include "pcap_ingress_config.svh"

module replay_fifo (
  input  logic                       axi_aclk,
  input  logic                       rst_n,
  input  logic                       enable,
  input  axis_types_pkg::buf_entry_t wr_entry,
  input  logic                       wr_en,
  output logic                       full,
  input  logic                       rd_en,
  output logic [`PI_OUT_W-1:0]       dout,
  output logic [`PI_QID_W-1:0]       dout_qid,
  output logic                       empty
);

  localparam int unsigned DEPTH = 1 << `PI_BUF_DEPTH_BITS;

  axis_types_pkg::buf_entry_t mem [DEPTH];

  logic [`PI_BUF_DEPTH_BITS-1:0] wr_ptr;
  logic [`PI_BUF_DEPTH_BITS-1:0] rd_ptr;
  logic [`PI_BUF_DEPTH_BITS:0]   count;
  logic                          half_sel;
  logic                          push;
  logic                          rd_ok;
  logic                          pull;
  axis_types_pkg::buf_entry_t    head_entry;

  assign full  = (count == DEPTH);
  assign empty = (count == '0);

  assign push  = wr_en && !full;
  assign rd_ok = rd_en && !empty;
  // Entry leaves on the upper-half read
  assign pull  = rd_ok && half_sel;

  // Fall-through read side
  assign head_entry = mem[rd_ptr];
  assign dout       = half_sel ? head_entry.packed_data[`PI_PACKED_W-1:`PI_OUT_W]
                               : head_entry.packed_data[`PI_OUT_W-1:0];
  assign dout_qid   = head_entry.qid;

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      half_sel <= 1'b0;
    end else if (!enable) begin
      // Flush, back to lower half
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      half_sel <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        half_sel <= !half_sel;
      end
      if (pull) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verilog/pkt_framer.sv ====
// ==========================================================
// Packet framer: metadata word, then packet words
// Tags each buffer entry with the decoded queue id
// ==========================================================
`timescale 1ns/1ps
`include "pcap_ingress_config.svh"

module pkt_framer (
  input  logic                       axi_aclk,
  input  logic                       rst_n,
  input  logic                       enable,
  input  axis_types_pkg::axis_beat_t head,
  input  logic                       empty,
  output logic                       pop,
  input  logic                       full,
  output axis_types_pkg::buf_entry_t wr_entry,
  output logic                       wr_en,
  output logic                       pkt_done,
  output logic                       state_bit
);

  axis_types_pkg::framer_state_e state;
  axis_types_pkg::framer_state_e next_state;

  logic [`PI_QID_W-1:0]      qid_r;
  logic [`PI_QID_W-1:0]      qid_next;
  logic [`PI_QID_W-1:0]      dec_qid;
  logic [`PI_NUM_QUEUES-1:0] dst_onehot;
  logic                      can_write;

  // Interleave each data byte with its strobe bit
  function automatic logic [`PI_PACKED_W-1:0] pack_bytes(
    input logic [`PI_TDATA_W-1:0]   data,
    input logic [`PI_TDATA_W/8-1:0] strb
  );
    logic [`PI_PACKED_W-1:0] packed_w;
    packed_w = '0;
    for (int i = 0; i < `PI_TDATA_W/8; i++) begin
      packed_w[9*i +: 9] = {strb[i], data[8*i +: 8]};
    end
    return packed_w;
  endfunction

  assign can_write = enable && !empty && !full;
  assign state_bit = (state == axis_types_pkg::WR_PKT);

  // Destination port bits sit on every other tuser bit
  always_comb begin
    dec_qid = qid_r;
    for (int q = 0; q < `PI_NUM_QUEUES; q++) begin
      dst_onehot[q] = head.tuser[`PI_DST_PORT_POS + 2*q];
    end
    // Non one-hot keeps the last queue
    for (int q = 0; q < `PI_NUM_QUEUES; q++) begin
      if (dst_onehot == (`PI_NUM_QUEUES'(1) << q)) begin
        dec_qid = `PI_QID_W'(q);
      end
    end
  end

  always_comb begin
    next_state           = state;
    qid_next             = qid_r;
    wr_en                = 1'b0;
    pop                  = 1'b0;
    pkt_done             = 1'b0;
    wr_entry.packed_data = pack_bytes(head.tdata, head.tstrb);
    wr_entry.qid         = qid_r;
    case (state)
      axis_types_pkg::WR_META: begin
        // tuser zero-extended, all strobes set, head stays
        wr_entry.packed_data = pack_bytes(`PI_TDATA_W'(head.tuser), '1);
        wr_entry.qid         = dec_qid;
        if (can_write) begin
          wr_en      = 1'b1;
          qid_next   = dec_qid;
          next_state = axis_types_pkg::WR_PKT;
        end
      end
      axis_types_pkg::WR_PKT: begin
        if (can_write) begin
          wr_en = 1'b1;
          pop   = 1'b1;
          if (head.tlast) begin
            pkt_done   = 1'b1;
            next_state = axis_types_pkg::WR_META;
          end
        end
      end
      default: next_state = axis_types_pkg::WR_META;
    endcase
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= axis_types_pkg::WR_META;
      qid_r <= '0;
    end else if (!enable) begin
      state <= axis_types_pkg::WR_META;
      qid_r <= '0;
    end else begin
      state <= next_state;
      qid_r <= qid_next;
    end
  end

endmodule

// ==== verilog/axis_skid_fifo.sv ====
// ==========================================================
// Stream skid FIFO, four entries with fall-through head
// Ready drops at three held beats
// ==========================================================
`timescale 1ns/1ps
`include "pcap_ingress_config.svh"

module axis_skid_fifo (
  input  logic                     axi_aclk,
  input  logic                     rst_n,
  input  logic                     enable,
  input  axis_types_pkg::axis_beat_t in_beat,
  input  logic                     in_valid,
  output logic                     in_ready,
  output axis_types_pkg::axis_beat_t head,
  output logic                     empty,
  input  logic                     pop
);

  localparam int unsigned DEPTH       = 1 << `PI_SKID_DEPTH_BITS;
  localparam int unsigned NEARLY_FULL = DEPTH - 1;

  // Beat storage
  axis_types_pkg::axis_beat_t mem [DEPTH];

  logic [`PI_SKID_DEPTH_BITS-1:0] wr_ptr;
  logic [`PI_SKID_DEPTH_BITS-1:0] rd_ptr;
  logic [`PI_SKID_DEPTH_BITS:0]   count;
  logic                           push;
  logic                           pull;

  // Leaves one slot spare for a beat already in flight
  assign in_ready = enable && (count < NEARLY_FULL);
  assign push     = in_valid && in_ready;
  assign pull     = pop && !empty;

  // Head shows as soon as count is non-zero
  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (!enable) begin
      // Flush while disabled
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pull) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verilog/replay_regs_pkg.sv ====
// ==========================================================
// APB bus types and register map for the replay registers
// ==========================================================
`include "pcap_ingress_config.svh"

package replay_regs_pkg;

  // APB requester side, setup then access phase
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // Completer side
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Mapped register offsets
  typedef enum logic [3:0] {
    CTRL      = `PI_REG_CTRL,
    STATUS    = `PI_REG_STATUS,
    PKT_COUNT = `PI_REG_PKT_COUNT
  } reg_addr_e;

endpackage

// ==== verilog/axis_types_pkg.sv ====
// ==========================================================
// Stream and buffer types for the ingress data path
// ==========================================================
`include "pcap_ingress_config.svh"

package axis_types_pkg;

  // One AXI4-Stream beat as held in the skid FIFO
  typedef struct packed {
    logic [`PI_TDATA_W-1:0]   tdata;
    logic [`PI_TDATA_W/8-1:0] tstrb;
    logic [`PI_TUSER_W-1:0]   tuser;
    logic                     tlast;
  } axis_beat_t;

  // Replay buffer entry
  // Byte i sits at [9i+8:9i], strobe bit on top
  typedef struct packed {
    logic [`PI_PACKED_W-1:0] packed_data;
    logic [`PI_QID_W-1:0]    qid;
  } buf_entry_t;

  // Framer FSM
  // Metadata word first, then the packet beats
  typedef enum logic {
    WR_META = 1'b0,
    WR_PKT  = 1'b1
  } framer_state_e;

endpackage

// ==== verilog/pcap_ingress_config.svh ====
// ==========================================================
// PCAP ingress configuration
// Widths, depths and APB register offsets
// ==========================================================
`ifndef PCAP_INGRESS_CONFIG_SVH
`define PCAP_INGRESS_CONFIG_SVH

// Stream geometry
`define PI_TDATA_W          64
`define PI_TUSER_W          32
`define PI_DST_PORT_POS     24

// Queue id from the one-hot destination port
`define PI_NUM_QUEUES       4
`define PI_QID_W            2

// Buffer word: 9 bits per byte, read out in two halves
`define PI_PACKED_W         72
`define PI_OUT_W            36

// FIFO depths as address bits
`define PI_SKID_DEPTH_BITS  2
`define PI_BUF_DEPTH_BITS   4

// APB register map
`define PI_REG_CTRL         4'h0
`define PI_REG_STATUS       4'h4
`define PI_REG_PKT_COUNT    4'h8

`endif
